// File: flist.f
+incdir+rtl
rtl/uart_cmd_pkg.sv
rtl/uart_link.sv
rtl/cmd_decode.sv
rtl/cmd_execute.sv
rtl/resp_format.sv
rtl/uart_cmd_top.sv
dv/tb_uart_cmd.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then judge the log
rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_uart_cmd -f flist.f -o tb_uart_cmd \
    && ./obj_dir/tb_uart_cmd > sim.log 2>&1 \
    || { echo "Build or simulation error, see sim.log"; exit 1; }
grep -q "TEST OK" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// File: dv/uart_cmd_golden.txt
# Columns: opcode addr data exp_status exp_value (hex bytes), then test group (decimal)
# Opcodes 57 write, 52 read, 41 add, 58 xor; status 4B ok, 45 error
# Group 1: reads straight after reset
52 00 00 4B 00 1
52 07 00 4B 00 1
52 0F 00 4B 00 1
# Group 2: write then read back
57 03 A5 4B A5 2
52 03 00 4B A5 2
57 0F 3C 4B 3C 2
52 0F 00 4B 3C 2
57 00 FF 4B FF 2
52 00 00 4B FF 2
# Group 3: add wraps mod 256, xor, read back
57 05 F0 4B F0 3
41 05 20 4B 10 3
58 05 5A 4B 4A 3
52 05 00 4B 4A 3
58 09 3C 4B 3C 3
52 09 00 4B 3C 3
# Group 4: unknown opcodes leave register 3 alone
5A 03 11 45 00 4
00 03 22 45 00 4
52 03 00 4B A5 4
# Group 5: addresses 16 and up, then register 0 must still read FF
57 10 77 45 00 5
52 10 00 45 00 5
41 80 01 45 00 5
58 FF 01 45 00 5
52 00 00 4B FF 5
# Group 6: burst with no idle time between frames
57 01 11 4B 11 6
57 02 22 4B 22 6
41 01 01 4B 12 6
58 02 FF 4B DD 6
52 01 00 4B 12 6
52 02 00 4B DD 6
63 01 00 45 00 6
41 0E 80 4B 80 6

// File: dv/tb_uart_cmd.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_cmd_defs.svh"

module tb_uart_cmd;

    localparam int BIT_CYC     = `UART_BAUD_DIV; // Clock cycles per serial bit
    localparam int MAX_REC     = 64;
    localparam int NUM_GROUPS  = 6;
    localparam int BURST_GROUP = 6;              // Frames sent back to back
    localparam int WAIT_MAX    = 150 * BIT_CYC;  // Longest wait for a start bit

    logic        clk;
    logic        rst_n;
    logic        rx_pin;
    logic        tx_pin;

    logic [7:0]  rec_op     [MAX_REC];
    logic [7:0]  rec_addr   [MAX_REC];
    logic [7:0]  rec_data   [MAX_REC];
    logic [7:0]  rec_status [MAX_REC]; // Expected reply bytes
    logic [7:0]  rec_value  [MAX_REC];
    int          rec_group  [MAX_REC];
    int          rec_count;

    logic [31:0] rng_state;
    int          pass_count;
    int          fail_count;
    int          group_errors;         // Failed checks in the running group
    bit          timed_out;

    uart_cmd_top dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .rx_pin (rx_pin),
        .tx_pin (tx_pin)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0}; // Stop, data, start
        for (int i = 0; i < 10; i++) begin
            rx_pin = frame[i]; // LSB first after the start bit
            repeat (BIT_CYC) @(negedge clk);
        end
    endtask

    task automatic idle_gap(input bit burst);
        int bits;
        bits = 0;
        if (!burst) begin
            rng_state = xorshift32(rng_state);
            bits      = int'(rng_state % 32'd21); // 0 to 20 bit periods
        end
        repeat (bits * BIT_CYC) @(negedge clk); // Line held at stop level
    endtask

    task automatic recv_byte(output logic [7:0] b);
        int waited;
        waited = 0;
        b      = 8'h00;
        while (tx_pin !== 1'b0 && waited < WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (tx_pin !== 1'b0) begin
            $display("Timeout: no start bit on tx_pin within %0d cycles", WAIT_MAX);
            timed_out = 1'b1;
            return;
        end
        repeat (BIT_CYC / 2) @(negedge clk); // Middle of the start bit
        if (tx_pin !== 1'b0) begin
            $display("Start bit on tx_pin did not stay low");
            group_errors++;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYC) @(negedge clk);
            b[i] = tx_pin;
        end
        repeat (BIT_CYC) @(negedge clk);
        if (tx_pin !== 1'b1) begin
            $display("Stop bit on tx_pin was low");
            group_errors++;
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [31:0] f_st;
        logic [31:0] f_val;
        logic [31:0] f_grp;
        rec_count = 0;
        fd = $fopen("dv/uart_cmd_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open golden file dv/uart_cmd_golden.txt");
            fail_count++;
            return;
        end
        while (!$feof(fd) && rec_count < MAX_REC) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h %d", f_op, f_addr, f_data, f_st, f_val, f_grp);
            if (n == 6) begin // Comment and blank lines fall through
                rec_op[rec_count]     = f_op[7:0];
                rec_addr[rec_count]   = f_addr[7:0];
                rec_data[rec_count]   = f_data[7:0];
                rec_status[rec_count] = f_st[7:0];
                rec_value[rec_count]  = f_val[7:0];
                rec_group[rec_count]  = int'(f_grp);
                rec_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic check_idle();
        bit went_low;
        went_low = 1'b0;
        for (int i = 0; i < 30 * BIT_CYC; i++) begin
            @(negedge clk);
            if (tx_pin !== 1'b1 && !went_low) begin
                $display("tx_pin left the idle level with no command sent");
                went_low = 1'b1;
            end
        end
        if (went_low) begin
            $display("idle check: failed");
            fail_count++;
        end else begin
            $display("idle check: passed, tx_pin high for 30 bit periods");
            pass_count++;
        end
    endtask

    task automatic run_group(input int g);
        int         first;
        int         last;
        logic [7:0] status;
        logic [7:0] value;
        first = -1;
        last  = -1;
        for (int r = 0; r < rec_count; r++) begin
            if (rec_group[r] == g) begin
                first = (first < 0) ? r : first;
                last  = r;
            end
        end
        if (first < 0) begin
            $display("group %0d: failed, no records in the golden file", g);
            fail_count++;
            return;
        end
        group_errors = 0;
        fork
            begin // Command sender
                for (int r = first; r <= last; r++) begin
                    send_byte(rec_op[r]);
                    idle_gap(g == BURST_GROUP);
                    send_byte(rec_addr[r]);
                    idle_gap(g == BURST_GROUP);
                    send_byte(rec_data[r]);
                    idle_gap(g == BURST_GROUP || r == last);
                end
            end
            begin // Reply monitor, replies in command order
                for (int r = first; r <= last; r++) begin
                    recv_byte(status);
                    if (timed_out) break;
                    if (status !== rec_status[r]) begin
                        $display("MISMATCH reply_status record %0d: expected 0x%02h, actual 0x%02h",
                                 r, rec_status[r], status);
                        group_errors++;
                    end
                    recv_byte(value);
                    if (timed_out) break;
                    if (value !== rec_value[r]) begin
                        $display("MISMATCH reply_value record %0d: expected 0x%02h, actual 0x%02h",
                                 r, rec_value[r], value);
                        group_errors++;
                    end
                end
            end
        join
        if (group_errors == 0 && !timed_out) begin
            $display("group %0d: passed, %0d commands", g, last - first + 1);
            pass_count++;
        end else begin
            $display("group %0d: failed, %0d check errors", g, group_errors);
            fail_count++;
        end
    endtask

    initial begin
        rx_pin     = 1'b1; // Serial line idle
        rst_n      = 1'b0;
        rng_state  = 32'h649d_ccaa;
        pass_count = 0;
        fail_count = 0;
        timed_out  = 1'b0;
        load_golden();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        check_idle();
        for (int g = 1; g <= NUM_GROUPS; g++) begin
            if (rec_count > 0 && !timed_out) begin
                run_group(g); // Skip the rest once the link stalls
            end
        end
        $display("Results: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && rec_count > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/uart_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_top (
    input  logic clk,
    input  logic rst_n,
    input  logic rx_pin,  // Serial command input
    output logic tx_pin   // Serial reply output
);

    import uart_cmd_pkg::*;

    logic         rx_valid;
    logic [7:0]   rx_data;
    logic         cmd_valid;
    cmd_op_e      cmd_op;
    logic [7:0]   cmd_addr;
    logic [7:0]   cmd_data;
    logic         cmd_bad_op;
    logic         res_valid;
    resp_status_e res_status;
    logic [7:0]   res_value;
    logic         tx_push;
    logic [7:0]   tx_data;
    logic         tx_ready;

    uart_link u_link (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_push  (tx_push),
        .tx_data  (tx_data),
        .rx_pin   (rx_pin),
        .tx_pin   (tx_pin),
        .tx_ready (tx_ready),
        .rx_valid (rx_valid),
        .rx_data  (rx_data)
    );

    cmd_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_data   (cmd_data),
        .cmd_bad_op (cmd_bad_op)
    );

    cmd_execute u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_data   (cmd_data),
        .cmd_bad_op (cmd_bad_op),
        .res_valid  (res_valid),
        .res_status (res_status),
        .res_value  (res_value)
    );

    resp_format u_format (
        .clk        (clk),
        .rst_n      (rst_n),
        .res_valid  (res_valid),
        .res_status (res_status),
        .res_value  (res_value),
        .tx_ready   (tx_ready),
        .tx_push    (tx_push),
        .tx_data    (tx_data)
    );

endmodule

`default_nettype wire

// File: rtl/resp_format.sv
`timescale 1ns/1ps
`default_nettype none

module resp_format (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       res_valid,
    input  uart_cmd_pkg::resp_status_e res_status,
    input  logic [7:0]                 res_value,
    input  logic                       tx_ready,  // FIFO has room
    output logic                       tx_push,
    output logic [7:0]                 tx_data
);

    import uart_cmd_pkg::*;

    fmt_state_e   state;
    resp_status_e status_q; // Held reply
    logic [7:0]   value_q;

    // Push straight off the room level so a full FIFO stalls same cycle
    assign tx_push = (state != FMT_IDLE) && tx_ready;
    assign tx_data = (state == FMT_STATUS) ? status_q : value_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FMT_IDLE;
        end else begin
            case (state)
                FMT_IDLE: begin
                    if (res_valid) begin
                        state <= FMT_STATUS;
                    end
                end
                FMT_STATUS: begin
                    if (tx_ready) begin
                        state <= FMT_VALUE;
                    end
                end
                FMT_VALUE: begin
                    if (tx_ready) begin
                        state <= FMT_IDLE;
                    end
                end
                default: state <= FMT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid && (state == FMT_IDLE)) begin
            status_q <= res_status;
            value_q  <= res_value;
        end
    end

    // Next result is three byte times away, longer than any stall
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> (state == FMT_IDLE))
        else $error("resp_format: result arrived while reply pending");

endmodule

`default_nettype wire

// File: rtl/cmd_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_cmd_defs.svh"

module cmd_execute (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cmd_valid,
    input  uart_cmd_pkg::cmd_op_e      cmd_op,
    input  logic [7:0]                 cmd_addr,
    input  logic [7:0]                 cmd_data,
    input  logic                       cmd_bad_op,
    output logic                       res_valid,  // One cycle after cmd_valid
    output uart_cmd_pkg::resp_status_e res_status,
    output logic [7:0]                 res_value
);

    import uart_cmd_pkg::*;

    localparam int REG_N  = `CMD_REG_COUNT;
    localparam int IDX_W  = $clog2(REG_N);

    logic [7:0]       regs [REG_N];
    logic [IDX_W-1:0] idx;
    logic [7:0]       cur_val;   // Addressed register
    logic [7:0]       new_val;   // Result of the operation
    logic             cmd_ok;    // Legal opcode and in range
    logic             do_write;

    assign idx     = cmd_addr[IDX_W-1:0];
    assign cur_val = regs[idx];

    always_comb begin
        cmd_ok   = !cmd_bad_op && (cmd_addr < 8'(REG_N));
        new_val  = 8'h00;
        do_write = 1'b0;
        case (cmd_op)
            OP_WRITE: begin
                new_val  = cmd_data;
                do_write = 1'b1;
            end
            OP_READ:  new_val = cur_val;
            OP_ADD: begin
                new_val  = cur_val + cmd_data; // Wraps mod 256
                do_write = 1'b1;
            end
            OP_XOR: begin
                new_val  = cur_val ^ cmd_data;
                do_write = 1'b1;
            end
            default:  cmd_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_N; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (cmd_valid && cmd_ok && do_write) begin
            regs[idx] <= new_val;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= cmd_valid;
        end
    end

    // Reply payload
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            res_status <= cmd_ok ? ST_OK : ST_ERR;
            res_value  <= cmd_ok ? new_val : 8'h00; // Errors read back zero
        end
    end

endmodule

`default_nettype wire

// File: rtl/cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rx_valid,   // Byte strobe from link
    input  logic [7:0]            rx_data,
    output logic                  cmd_valid,  // One-cycle command strobe
    output uart_cmd_pkg::cmd_op_e cmd_op,
    output logic [7:0]            cmd_addr,
    output logic [7:0]            cmd_data,
    output logic                  cmd_bad_op  // Opcode byte not recognised
);

    import uart_cmd_pkg::*;

    dec_state_e state;
    logic [7:0] op_byte;  // Raw opcode as received
    logic       op_legal;

    // Match against every defined opcode
    always_comb begin
        case (op_byte)
            OP_WRITE, OP_READ, OP_ADD, OP_XOR: op_legal = 1'b1;
            default:                           op_legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= DEC_OP;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            if (rx_valid) begin
                case (state)
                    DEC_OP:   state <= DEC_ADDR;
                    DEC_ADDR: state <= DEC_DATA;
                    DEC_DATA: begin
                        state     <= DEC_OP;
                        cmd_valid <= 1'b1; // Third byte completes command
                    end
                    default:  state <= DEC_OP;
                endcase
            end
        end
    end

    // Command fields are valid with cmd_valid
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            case (state)
                DEC_OP: begin
                    op_byte <= rx_data;
                end
                DEC_ADDR: begin
                    cmd_addr <= rx_data;
                end
                DEC_DATA: begin
                    cmd_data   <= rx_data;
                    cmd_op     <= cmd_op_e'(op_byte);
                    cmd_bad_op <= !op_legal;
                end
                default: begin
                    op_byte <= op_byte;
                end
            endcase
        end
    end

    // Each received byte must advance the FSM only once
    a_rx_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |=> !rx_valid)
        else $error("cmd_decode: rx_valid held for two cycles");

endmodule

`default_nettype wire

// File: rtl/uart_link.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_cmd_defs.svh"

module uart_link #(
    parameter int BAUD_DIV = `UART_BAUD_DIV // Clock cycles per bit
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_push,  // Enqueue strobe
    input  logic [7:0] tx_data,
    input  logic       rx_pin,   // Asynchronous serial input
    output logic       tx_pin,
    output logic       tx_ready, // FIFO has room
    output logic       rx_valid, // One-cycle pulse per byte
    output logic [7:0] rx_data
);

    localparam int DEPTH  = `UART_TX_FIFO_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int BAUD_W = $clog2(BAUD_DIV + 1);
    localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(BAUD_DIV - 1);
    localparam logic [BAUD_W-1:0] BAUD_HALF = BAUD_W'(BAUD_DIV / 2);
    localparam logic [CNT_W-1:0]  CNT_FULL  = CNT_W'(DEPTH);

    logic [7:0]        tx_mem [DEPTH]; // Circular transmit buffer
    logic [PTR_W-1:0]  tx_head;        // Next byte to send
    logic [PTR_W-1:0]  tx_tail;        // Next free slot
    logic [CNT_W-1:0]  tx_count;
    logic              tx_busy;        // Frame on the line
    logic [BAUD_W-1:0] tx_baud_cnt;
    logic [3:0]        tx_bit_idx;     // Bits already driven
    logic [9:0]        tx_shift;       // Stop, data, start
    logic              push_ok;
    logic              tx_done;
    logic              pop;

    logic              rx_sync1;
    logic              rx_sync2;
    logic              rx_busy;
    logic [BAUD_W-1:0] rx_baud_cnt;
    logic [3:0]        rx_bit_idx;
    logic [8:0]        rx_shift;       // Start plus 8 data bits

    assign tx_ready = (tx_count < CNT_FULL);
    assign push_ok  = tx_push && tx_ready;
    // Last cycle of the stop bit
    assign tx_done  = tx_busy && (tx_baud_cnt == BAUD_LAST) && (tx_bit_idx == 4'd10);
    // Load on idle, or right at frame end for back-to-back frames
    assign pop      = (tx_count != '0) && (!tx_busy || tx_done);

    always_ff @(posedge clk) begin
        if (push_ok) begin
            tx_mem[tx_tail] <= tx_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_head  <= '0;
            tx_tail  <= '0;
            tx_count <= '0;
        end else begin
            if (push_ok) begin
                tx_tail <= tx_tail + 1'b1; // Wraps at depth
            end
            if (pop) begin
                tx_head <= tx_head + 1'b1;
            end
            case ({push_ok, pop})
                2'b10:   tx_count <= tx_count + 1'b1;
                2'b01:   tx_count <= tx_count - 1'b1;
                default: tx_count <= tx_count; // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy     <= 1'b0;
            tx_baud_cnt <= '0;
            tx_bit_idx  <= '0;
            tx_shift    <= '1;
            tx_pin      <= 1'b1; // Line idles high
        end else if (pop) begin
            tx_busy     <= 1'b1;
            tx_baud_cnt <= '0;
            tx_bit_idx  <= '0;
            tx_shift    <= {1'b1, tx_mem[tx_head], 1'b0};
        end else if (tx_done) begin
            tx_busy <= 1'b0; // Pin stays at stop level
        end else if (tx_busy) begin
            if (tx_baud_cnt == '0) begin
                tx_pin     <= tx_shift[0]; // LSB first
                tx_shift   <= {1'b1, tx_shift[9:1]};
                tx_bit_idx <= tx_bit_idx + 1'b1;
            end
            tx_baud_cnt <= (tx_baud_cnt == BAUD_LAST) ? '0 : tx_baud_cnt + 1'b1;
        end
    end

    // Two-flop synchroniser on the serial input
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_sync1 <= 1'b1;
            rx_sync2 <= 1'b1;
        end else begin
            rx_sync1 <= rx_pin;
            rx_sync2 <= rx_sync1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_busy     <= 1'b0;
            rx_baud_cnt <= '0;
            rx_bit_idx  <= '0;
            rx_valid    <= 1'b0;
        end else begin
            rx_valid <= 1'b0; // Pulse only
            if (!rx_busy) begin
                if (!rx_sync2) begin
                    rx_busy     <= 1'b1;      // Start edge seen
                    rx_baud_cnt <= BAUD_HALF; // First sample mid start bit
                    rx_bit_idx  <= '0;
                end
            end else if (rx_baud_cnt != BAUD_LAST) begin
                rx_baud_cnt <= rx_baud_cnt + 1'b1;
            end else begin
                rx_baud_cnt <= '0;
                rx_bit_idx  <= rx_bit_idx + 1'b1;
                if (rx_bit_idx == 4'd9) begin
                    rx_valid <= 1'b1; // Mid stop bit
                    rx_busy  <= 1'b0;
                end
            end
        end
    end

    // Sample point datapath
    always_ff @(posedge clk) begin
        if (rx_busy && (rx_baud_cnt == BAUD_LAST)) begin
            if (rx_bit_idx == 4'd9) begin
                rx_data <= rx_shift[8:1]; // Drop start bit
            end else begin
                rx_shift <= {rx_sync2, rx_shift[8:1]};
            end
        end
    end

    // Formatter must respect the room level
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        tx_push |-> tx_ready)
        else $error("uart_link: push into full transmit FIFO");

    // Count tracks the pointer distance and stays within the depth
    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_count <= CNT_FULL) && (tx_count[PTR_W-1:0] == PTR_W'(tx_tail - tx_head)))
        else $error("uart_link: FIFO count out of step with pointers");

endmodule

`default_nettype wire

// File: rtl/uart_cmd_pkg.sv
`default_nettype none

package uart_cmd_pkg;

    // Opcode byte values, ASCII letters W R A X
    typedef enum logic [7:0] {
        OP_WRITE = 8'h57,
        OP_READ  = 8'h52,
        OP_ADD   = 8'h41,
        OP_XOR   = 8'h58
    } cmd_op_e;

    // Reply status byte, ASCII K or E
    typedef enum logic [7:0] {
        ST_OK  = 8'h4B,
        ST_ERR = 8'h45
    } resp_status_e;

    typedef enum logic [1:0] {
        DEC_OP,   // Waiting for opcode byte
        DEC_ADDR, // Waiting for address byte
        DEC_DATA  // Waiting for data byte
    } dec_state_e;

    typedef enum logic [1:0] {
        FMT_IDLE,
        FMT_STATUS, // Status byte pending
        FMT_VALUE   // Value byte pending
    } fmt_state_e;

endpackage

`default_nettype wire

// File: rtl/uart_cmd_defs.svh
`ifndef UART_CMD_DEFS_SVH
`define UART_CMD_DEFS_SVH

// Serial link timing
`define UART_BAUD_DIV 8 // Clock cycles per bit

// Transmit side buffering
`define UART_TX_FIFO_DEPTH 64 // Entries, power of two

// Register file behind the command port
`define CMD_REG_COUNT 16 // 8-bit registers

`endif
